// ==== hdl/fir_consts.svh ====
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath widths of the modeled DSP slice
////////////////////////////////////////////////////////////

// A and D sample ports
`define FIR_A_W 26

// Pre-adder output, one bit of growth over A and D
`define FIR_AD_W 27

// Coefficient port and both coefficient registers
`define FIR_B_W 18

// Accumulator, C port and the partial sum cascade
`define FIR_P_W 48

////////////////////////////////////////////////////////////
// Pipeline and pattern detect
////////////////////////////////////////////////////////////

// Input, pre-adder, multiplier and P registers
`define FIR_LATENCY 4

// Pattern is compared only where the mask bit is set
`define FIR_PATTERN 48'h0000_0000_0000
`define FIR_MASK 48'hFFFF_0000_0000

`endif

// ==== hdl/dsp_op_pkg.sv ====
package dsp_op_pkg;

    ////////////////////////////////////////////////////////////
    // Per-sample opcodes, in the spirit of INMODE and OPMODE
    ////////////////////////////////////////////////////////////

    // Pre-adder function
    typedef enum logic [1:0] {
        PRE_D_PLUS_A  = 2'b00,
        PRE_D_MINUS_A = 2'b01,
        PRE_A_ONLY    = 2'b10
    } preadd_op_e;

    // Post-adder function applied to the product
    // POST_ADD_PCIN takes the partial sum of the previous tap
    typedef enum logic [1:0] {
        POST_ADD_C     = 2'b00,
        POST_SUB_C     = 2'b01,
        POST_ADD_PCIN  = 2'b10,
        POST_MULT_ONLY = 2'b11
    } post_op_e;

endpackage

// ==== hdl/dsp_types_pkg.sv ====
`include "fir_consts.svh"

package dsp_types_pkg;

    ////////////////////////////////////////////////////////////
    // Records passed between the pipeline stages
    ////////////////////////////////////////////////////////////

    // One input sample with its opcodes
    // a, d and c are two's complement
    typedef struct packed {
        logic                   valid;
        logic [`FIR_A_W-1:0]    a;
        logic [`FIR_A_W-1:0]    d;
        logic [`FIR_P_W-1:0]    c;
        dsp_op_pkg::preadd_op_e pre_op;
        dsp_op_pkg::post_op_e   post_op;
    } tap_in_t;

    // Output of the multiplier register
    // C and the post-adder opcode ride along with the product
    typedef struct packed {
        logic                 valid;
        logic [`FIR_P_W-1:0]  prod;
        logic [`FIR_P_W-1:0]  c;
        dsp_op_pkg::post_op_e post_op;
    } product_t;

    // Result of the tap, pattern flag aligned with p
    typedef struct packed {
        logic                valid;
        logic [`FIR_P_W-1:0] p;
        logic                pattern;
    } tap_out_t;

endpackage

// ==== hdl/coeff_bank.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module coeff_bank (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [`FIR_B_W-1:0] coef_i,
    input  logic                load_i,
    input  logic                update_i,
    output logic [`FIR_B_W-1:0] coef_active_o,
    output logic [`FIR_B_W-1:0] bcout_o
);

    // Staged coefficient, also the cascade toward the next tap
    logic [`FIR_B_W-1:0] coef_stage_q;
    // Coefficient seen by the multiplier
    logic [`FIR_B_W-1:0] coef_active_q;

    ////////////////////////////////////////////////////////////
    // Load stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            coef_stage_q <= '0;
        end else if (load_i) begin
            coef_stage_q <= coef_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Update stage
    ////////////////////////////////////////////////////////////

    // With load and update together the old staged value moves on
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            coef_active_q <= '0;
        end else if (update_i) begin
            coef_active_q <= coef_stage_q;
        end
    end

    assign coef_active_o = coef_active_q;
    assign bcout_o       = coef_stage_q;

endmodule

// ==== hdl/preadd_mult.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module preadd_mult (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  dsp_types_pkg::tap_in_t  sample_i,
    input  logic [`FIR_B_W-1:0]     coef_i,
    output dsp_types_pkg::product_t prod_o
);

    import dsp_op_pkg::*;
    import dsp_types_pkg::*;

    localparam int MULT_W = `FIR_AD_W + `FIR_B_W;

    tap_in_t                     s1_q;
    logic signed [`FIR_AD_W-1:0] a_ext;
    logic signed [`FIR_AD_W-1:0] d_ext;
    logic signed [`FIR_AD_W-1:0] ad_d;
    logic signed [`FIR_AD_W-1:0] ad_q;
    logic                        s2_vld_q;
    logic [`FIR_P_W-1:0]         s2_c_q;
    post_op_e                    s2_post_q;
    logic signed [MULT_W-1:0]    mult_d;
    product_t                    prod_q;

    ////////////////////////////////////////////////////////////
    // Stage 1, input register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        s1_q <= sample_i;
        if (!rst_n_i) begin
            s1_q.valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, pre-adder
    ////////////////////////////////////////////////////////////

    // Sign extend to the pre-adder width so the sum cannot overflow
    assign a_ext = $signed(s1_q.a);
    assign d_ext = $signed(s1_q.d);

    always_comb begin
        case (s1_q.pre_op)
            PRE_D_PLUS_A:  ad_d = d_ext + a_ext;
            PRE_D_MINUS_A: ad_d = d_ext - a_ext;
            default:       ad_d = a_ext;
        endcase
    end

    always_ff @(posedge clk_i) begin
        ad_q      <= ad_d;
        s2_c_q    <= s1_q.c;
        s2_post_q <= s1_q.post_op;
        s2_vld_q  <= s1_q.valid;
        if (!rst_n_i) begin
            s2_vld_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 3, multiplier with the active coefficient
    ////////////////////////////////////////////////////////////

    assign mult_d = ad_q * $signed(coef_i);

    always_ff @(posedge clk_i) begin
        prod_q.prod    <= {{(`FIR_P_W - MULT_W){mult_d[MULT_W-1]}}, mult_d};
        prod_q.c       <= s2_c_q;
        prod_q.post_op <= s2_post_q;
        prod_q.valid   <= s2_vld_q;
        if (!rst_n_i) begin
            prod_q.valid <= 1'b0;
        end
    end

    assign prod_o = prod_q;

endmodule

// ==== hdl/alu_accum.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module alu_accum (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  dsp_types_pkg::product_t prod_i,
    input  logic [`FIR_P_W-1:0]     pcin_i,
    output dsp_types_pkg::tap_out_t out_o,
    output logic [`FIR_P_W-1:0]     pcout_o
);

    import dsp_op_pkg::*;
    import dsp_types_pkg::*;

    logic [`FIR_P_W-1:0] operand;
    logic                subtract;
    logic [`FIR_P_W-1:0] sum_d;
    logic                pattern_d;
    tap_out_t            out_q;

    ////////////////////////////////////////////////////////////
    // Post-adder operand select
    ////////////////////////////////////////////////////////////

    // PCIN is expected in the same cycle its product arrives here
    always_comb begin
        case (prod_i.post_op)
            POST_ADD_C:    operand = prod_i.c;
            POST_SUB_C:    operand = prod_i.c;
            POST_ADD_PCIN: operand = pcin_i;
            default:       operand = '0;
        endcase
    end

    assign subtract = (prod_i.post_op == POST_SUB_C);

    ////////////////////////////////////////////////////////////
    // Post-adder and pattern detect
    ////////////////////////////////////////////////////////////

    // Sum wraps at the accumulator width
    always_comb begin
        if (subtract) begin
            sum_d = prod_i.prod - operand;
        end else begin
            sum_d = prod_i.prod + operand;
        end
    end

    // Only bits selected by the mask take part in the compare
    assign pattern_d = (((sum_d ^ `FIR_PATTERN) & `FIR_MASK) == '0);

    ////////////////////////////////////////////////////////////
    // P register
    ////////////////////////////////////////////////////////////

    // P and pattern hold their last result between samples
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else begin
            out_q.valid <= prod_i.valid;
            if (prod_i.valid) begin
                out_q.p       <= sum_d;
                out_q.pattern <= pattern_d;
            end
        end
    end

    assign out_o   = out_q;
    // Cascade to the next tap is P itself
    assign pcout_o = out_q.p;

endmodule

// ==== hdl/fir_tap_top.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module fir_tap_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  dsp_types_pkg::tap_in_t  sample_i,
    input  logic [`FIR_B_W-1:0]     coef_i,
    input  logic                    load_i,
    input  logic                    update_i,
    input  logic [`FIR_P_W-1:0]     pcin_i,
    output dsp_types_pkg::tap_out_t out_o,
    output logic [`FIR_P_W-1:0]     pcout_o,
    output logic [`FIR_B_W-1:0]     bcout_o
);

    import dsp_types_pkg::*;

    // Coefficient used by the multiplier stage
    logic [`FIR_B_W-1:0] coef_active;
    // Multiplier register toward the post-adder
    product_t            prod;

    ////////////////////////////////////////////////////////////
    // Coefficient registers
    ////////////////////////////////////////////////////////////

    coeff_bank u_coeff_bank (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .coef_i        (coef_i),
        .load_i        (load_i),
        .update_i      (update_i),
        .coef_active_o (coef_active),
        .bcout_o       (bcout_o)
    );

    ////////////////////////////////////////////////////////////
    // Datapath, three stages then the P register
    ////////////////////////////////////////////////////////////

    preadd_mult u_preadd_mult (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sample_i (sample_i),
        .coef_i   (coef_active),
        .prod_o   (prod)
    );

    alu_accum u_alu_accum (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .prod_i  (prod),
        .pcin_i  (pcin_i),
        .out_o   (out_o),
        .pcout_o (pcout_o)
    );

endmodule

// ==== verification/fir_tap_properties.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module fir_tap_properties (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input dsp_types_pkg::tap_in_t  sample_i,
    input logic                    load_i,
    input logic [`FIR_B_W-1:0]     bcout_i,
    input dsp_types_pkg::tap_out_t out_i
);

    ////////////////////////////////////////////////////////////
    // Pipeline timing
    ////////////////////////////////////////////////////////////

    // Every accepted sample shows up once, a fixed latency later
    a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_i.valid == $past(sample_i.valid, `FIR_LATENCY))
        else $error("output valid does not follow input valid by the pipeline latency");

    // Synchronous reset clears the result valid at the next edge
    a_valid_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !out_i.valid)
        else $error("output valid is high while the tap is in reset");

    ////////////////////////////////////////////////////////////
    // Coefficient cascade
    ////////////////////////////////////////////////////////////

    a_bcout_on_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$stable(bcout_i) |-> $past(load_i))
        else $error("coefficient cascade changed without a load strobe");

endmodule

bind fir_tap_top fir_tap_properties i_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sample_i (sample_i),
    .load_i   (load_i),
    .bcout_i  (bcout_o),
    .out_i    (out_o)
);

// ==== verification/fir_tap_checker.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module fir_tap_checker (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  dsp_types_pkg::tap_out_t out_i,
    input  logic [`FIR_P_W-1:0]     pcout_i,
    input  logic                    load_i,
    input  logic [`FIR_B_W-1:0]     coef_i,
    input  logic [`FIR_B_W-1:0]     bcout_i,
    input  dsp_types_pkg::tap_out_t exp_i,
    input  logic [127:0]            exp_name_i,
    input  logic [`FIR_P_W-1:0]     exp_pcin_i,
    output int                      pass_cnt_o,
    output int                      fail_cnt_o,
    output int                      pending_o
);

    import dsp_types_pkg::*;

    // One expected result waiting for the P register
    typedef struct packed {
        logic [127:0]        name;
        logic [`FIR_P_W-1:0] pcin;
        tap_out_t            res;
    } exp_rec_t;

    exp_rec_t            exp_q [$];
    exp_rec_t            head;
    // Staged coefficient as the load rule predicts it
    logic [`FIR_B_W-1:0] bcout_model;

    ////////////////////////////////////////////////////////////
    // Result and cascade compare
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_q.delete();
            bcout_model = '0;
        end else begin
            // A result never belongs to a sample pushed in this cycle
            if (exp_i.valid) begin
                exp_q.push_back('{name: exp_name_i, pcin: exp_pcin_i, res: exp_i});
            end
            if (out_i.valid && exp_q.size() == 0) begin
                $display("ERROR a result p=%h came out with no sample waiting for it", out_i.p);
                fail_cnt_o++;
            end else if (out_i.valid) begin
                head = exp_q.pop_front();
                if (out_i.p !== head.res.p || out_i.pattern !== head.res.pattern ||
                    pcout_i !== head.res.p) begin
                    $display("MISMATCH %0s expected p=%h pattern=%b actual p=%h pattern=%b",
                             head.name, head.res.p, head.res.pattern, out_i.p, out_i.pattern);
                    $display("    pcout=%h pcin=%h", pcout_i, head.pcin);
                    fail_cnt_o++;
                end else begin
                    $display("PASS %0s p=%h pattern=%b", head.name, out_i.p, out_i.pattern);
                    pass_cnt_o++;
                end
            end
            // A load shows on the cascade one cycle later
            if (bcout_i !== bcout_model) begin
                $display("MISMATCH bcout expected %h actual %h", bcout_model, bcout_i);
                fail_cnt_o++;
            end
            if (load_i) begin
                bcout_model = coef_i;
            end
        end
        pending_o = exp_q.size();
    end

endmodule

// ==== verification/fir_tap_tb.sv ====
`timescale 1ns/1ps

`include "fir_consts.svh"

module fir_tap_tb;

    import dsp_op_pkg::*;
    import dsp_types_pkg::*;

    localparam int MAX_VEC = 64;

    logic                clk;
    logic                rst_n;
    tap_in_t             sample;
    logic [`FIR_B_W-1:0] coef;
    logic                load;
    logic                update;
    logic [`FIR_P_W-1:0] pcin;
    tap_out_t            result;
    logic [`FIR_P_W-1:0] pcout;
    logic [`FIR_B_W-1:0] bcout;

    // Expected result handed to the checker with each sample
    tap_out_t            exp_res;
    logic [127:0]        exp_name;
    logic [`FIR_P_W-1:0] exp_pcin;
    int                  pass_cnt;
    int                  fail_cnt;
    int                  pending;

    // Vector table filled from the file before reset
    logic [7:0]          vec_kind [MAX_VEC];
    logic [127:0]        vec_name [MAX_VEC];
    tap_in_t             vec_in   [MAX_VEC];
    logic [`FIR_P_W-1:0] vec_pcin [MAX_VEC];
    tap_out_t            vec_exp  [MAX_VEC];
    logic [`FIR_B_W-1:0] vec_coef [MAX_VEC];
    int                  n_vec;
    int                  n_samples;
    logic                loaded;

    // pcin reaches the post-adder three cycles after its sample
    logic [`FIR_P_W-1:0] pcin_dly [3];
    integer              seed;

    fir_tap_top i_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .sample_i (sample),
        .coef_i   (coef),
        .load_i   (load),
        .update_i (update),
        .pcin_i   (pcin),
        .out_o    (result),
        .pcout_o  (pcout),
        .bcout_o  (bcout)
    );

    fir_tap_checker i_chk (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .out_i      (result),
        .pcout_i    (pcout),
        .load_i     (load),
        .coef_i     (coef),
        .bcout_i    (bcout),
        .exp_i      (exp_res),
        .exp_name_i (exp_name),
        .exp_pcin_i (exp_pcin),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt),
        .pending_o  (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////////////////////////

    task automatic read_vectors();
        int                  fd;
        int                  cnt;
        int                  pre;
        int                  post;
        int                  pat;
        string               line;
        logic [63:0]         kind;
        logic [127:0]        name;
        logic [`FIR_A_W-1:0] a;
        logic [`FIR_A_W-1:0] d;
        logic [`FIR_P_W-1:0] c;
        logic [`FIR_P_W-1:0] pc;
        logic [`FIR_P_W-1:0] p;
        logic [`FIR_B_W-1:0] cf;
        fd = $fopen("verification/fir_tap_vectors.txt", "r");
        if (fd == 0) begin
            $display("Vector file verification/fir_tap_vectors.txt could not be opened");
            return;
        end
        while ($fgets(line, fd) != 0 && n_vec < MAX_VEC) begin
            kind = '0;
            cnt  = $sscanf(line, "%s", kind);
            if (cnt < 1 || kind[7:0] == "#") begin
                continue;
            end
            if (kind[7:0] == "L") begin
                cnt = $sscanf(line, "%s %h", kind, cf);
                vec_coef[n_vec] = cf;
            end else if (kind[7:0] == "S" || kind[7:0] == "B") begin
                cnt = $sscanf(line, "%s %s %d %d %h %h %h %h %h %d",
                              kind, name, pre, post, a, d, c, pc, p, pat);
                vec_name[n_vec] = name;
                vec_in[n_vec]   = '{valid: 1'b1, a: a, d: d, c: c,
                                    pre_op: preadd_op_e'(pre[1:0]),
                                    post_op: post_op_e'(post[1:0])};
                vec_pcin[n_vec] = pc;
                vec_exp[n_vec]  = '{valid: 1'b1, p: p, pattern: pat[0]};
                n_samples++;
            end else if (kind[7:0] != "U") begin
                $display("Skipping a vector line of unknown kind: %0s", line);
                continue;
            end
            vec_kind[n_vec] = kind[7:0];
            n_vec++;
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic step(input tap_in_t s, input logic [`FIR_P_W-1:0] pc,
                        input logic [127:0] name, input tap_out_t ex,
                        input logic ld, input logic upd);
        @(negedge clk);
        sample      = s;
        exp_res     = ex;
        exp_name    = name;
        exp_pcin    = pc;
        load        = ld;
        update      = upd;
        pcin        = pcin_dly[2];
        pcin_dly[2] = pcin_dly[1];
        pcin_dly[1] = pcin_dly[0];
        pcin_dly[0] = pc;
    endtask

    task automatic idle(input int n);
        repeat (n) step('0, '0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic run_vectors();
        int gap;
        int i;
        for (i = 0; i < n_vec; i++) begin
            case (vec_kind[i])
                // Coefficient changes wait for an empty pipeline
                "L": begin
                    idle(`FIR_LATENCY + 1);
                    coef = vec_coef[i];
                    step('0, '0, '0, '0, 1'b1, 1'b0);
                end
                "U": begin
                    idle(`FIR_LATENCY + 1);
                    step('0, '0, '0, '0, 1'b0, 1'b1);
                end
                "S": begin
                    gap = $unsigned($random(seed)) % 4;
                    idle(gap);
                    step(vec_in[i], vec_pcin[i], vec_name[i], vec_exp[i], 1'b0, 1'b0);
                end
                default: begin
                    step(vec_in[i], vec_pcin[i], vec_name[i], vec_exp[i], 1'b0, 1'b0);
                end
            endcase
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (pending != 0 && waited < `FIR_LATENCY + 4) begin
            idle(1);
            waited++;
        end
        if (pending != 0) begin
            $display("%0d expected results never came out of the tap", pending);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        seed      = 76347;
        rst_n     = 1'b0;
        sample    = '0;
        coef      = '0;
        load      = 1'b0;
        update    = 1'b0;
        pcin      = '0;
        exp_res   = '0;
        exp_name  = '0;
        exp_pcin  = '0;
        pcin_dly  = '{default: '0};
        n_vec     = 0;
        n_samples = 0;
        loaded    = 1'b0;
        read_vectors();
        loaded = 1'b1;
        if (n_vec == 0) begin
            $display("No vectors were read, nothing was tested");
        end else begin
            repeat (5) @(negedge clk);
            rst_n = 1'b1;
            run_vectors();
            drain();
        end
        $display("Tests: %0d passed, %0d failed, %0d missing", pass_cnt, fail_cnt, pending);
        if (n_samples > 0 && fail_cnt == 0 && pending == 0 && pass_cnt == n_samples) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Each vector needs at most a drain, a gap and the latency
    initial begin
        wait (loaded);
        repeat (n_vec * 12 + 100) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", n_vec * 12 + 100);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== verification/fir_tap_vectors.txt ====
# L coef: load coefficient (hex), U: update, S: sample after random gap, B: back to back
# S/B name pre_op post_op a d c pcin exp_p exp_pattern (ops decimal, rest hex)
L 00003
U
S plus_c_pos 0 0 0000010 0000020 000000000100 000000000000 000000000190 1
S plus_c_neg 0 0 3FFFFFB 3FFFF00 000000000010 000000000000 FFFFFFFFFD01 0
S plus_c_mixed 0 0 0001000 3FFD000 000000007000 000000000000 000000001000 1
S dmina_subc 1 1 0000050 0000010 000000000040 000000000000 FFFFFFFFFF00 0
S aonly_mult 2 3 0000123 0000999 000000000ABC 000000000000 000000000369 1
S wrap_subc 2 1 0000001 0000000 800000000000 000000000000 800000000003 0
S wrap_addc 0 0 0000001 0000001 7FFFFFFFFFFF 000000000000 800000000005 0
S pat_edge 2 0 0000001 0000000 0000FFFFFFFC 000000000000 0000FFFFFFFF 1
S pat_miss 2 0 0000002 0000000 0000FFFFFFFC 000000000000 000100000002 0
S add_pcin 0 2 0000004 0000006 000000005555 123456789ABC 123456789ADA 0
S add_pcin_neg 1 2 0000010 0000000 000000000000 000000000100 0000000000D0 1
L 00005
S staged_only 2 3 0000007 0000000 000000000000 000000000000 000000000015 1
U
S after_update 2 3 0000007 0000000 000000000000 000000000000 000000000023 1
L 3FFFE
U
S neg_coef 0 0 0000010 0000005 00000000002A 000000000000 000000000000 1
S neg_coef_neg 1 3 0000003 0000001 000000000000 000000000000 000000000004 1
B bb0 2 0 0000001 0000000 000000000010 000000000000 00000000000E 1
B bb1 2 1 0000002 0000000 000000000010 000000000000 FFFFFFFFFFEC 0
B bb2 0 2 0000001 0000002 000000000000 000000000100 0000000000FA 1
B bb3 1 3 0000005 0000001 000000000000 000000000000 000000000008 1
B bb4 2 2 0000003 0000000 000000000000 000000000006 000000000000 1

// ==== files.f ====
+incdir+hdl
hdl/dsp_op_pkg.sv
hdl/dsp_types_pkg.sv
hdl/coeff_bank.sv
hdl/preadd_mult.sv
hdl/alu_accum.sv
hdl/fir_tap_top.sv
verification/fir_tap_properties.sv
verification/fir_tap_checker.sv
verification/fir_tap_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module fir_tap_tb \
    -o fir_tap_sim || exit 1
sim_out="$(./obj_dir/fir_tap_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Everything OK" && echo "Run passed" || { echo "Run failed"; exit 1; }
